// ==== verilog/riscv_pkg.sv ====
package riscv_pkg;

   // Machine word width
   localparam int XLEN = 32;

   typedef logic [XLEN-1:0] word_t;     // Data, address and instruction word
   typedef logic [4:0]      reg_addr_t; // Register index x0..x31
   typedef logic [3:0]      alu_op_t;   // ALU operation select

   // ALU operations
   localparam alu_op_t ALU_ADD = 4'd0;
   localparam alu_op_t ALU_SUB = 4'd1;
   localparam alu_op_t ALU_AND = 4'd2;
   localparam alu_op_t ALU_OR  = 4'd3;
   localparam alu_op_t ALU_XOR = 4'd4;
   localparam alu_op_t ALU_SLT = 4'd5;

   // Major opcodes of the supported subset
   localparam logic [6:0] OPC_RTYPE  = 7'b0110011; // ADD SUB AND OR XOR SLT
   localparam logic [6:0] OPC_ITYPE  = 7'b0010011; // ADDI
   localparam logic [6:0] OPC_LOAD   = 7'b0000011; // LW
   localparam logic [6:0] OPC_STORE  = 7'b0100011; // SW
   localparam logic [6:0] OPC_BRANCH = 7'b1100011; // BEQ

   // ADDI x0, x0, 0
   localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

// ==== verilog/riscv_fetch.sv ====
`timescale 1ns/1ps

module riscv_fetch #(
   parameter riscv_pkg::word_t RESET_PC = '0
) (
   input  logic             clk,
   input  logic             reset_i,
   input  logic             stall_i,         // Load-use hold from decode
   input  logic             branch_taken_i,  // Redirect from execute
   input  riscv_pkg::word_t branch_target_i,
   input  riscv_pkg::word_t inst_i,
   output riscv_pkg::word_t inst_addr_o,
   output logic             inst_ce_o,
   output riscv_pkg::word_t id_instr_o,
   output riscv_pkg::word_t id_pc_o
);

   riscv_pkg::word_t pc_q;
   logic             ce_q;

   // PC register and next-PC choice
   always_ff @(posedge clk) begin
      if (reset_i) begin
         pc_q <= RESET_PC;
         ce_q <= 1'b0;
      end else begin
         ce_q <= 1'b1;                            // Fetch runs from here on
         if (branch_taken_i) begin
            pc_q <= branch_target_i;              // Taken BEQ wins over stall
         end else if (ce_q && !stall_i) begin
            pc_q <= pc_q + riscv_pkg::word_t'(4);
         end
      end
   end

   // Fetch/decode register, instruction part
   always_ff @(posedge clk) begin
      if (reset_i) begin
         id_instr_o <= riscv_pkg::NOP_INSTR;
      end else if (branch_taken_i) begin
         id_instr_o <= riscv_pkg::NOP_INSTR;      // Squash younger fetch
      end else if (!stall_i) begin
         id_instr_o <= ce_q ? inst_i : riscv_pkg::NOP_INSTR;
      end
   end

   // PC of the instruction handed to decode
   always_ff @(posedge clk) begin
      if (!stall_i) begin
         id_pc_o <= pc_q;
      end
   end

   assign inst_addr_o = pc_q;
   assign inst_ce_o   = ce_q;

   // Branch targets come from execute, so alignment depends on the immediates
   a_pc_aligned: assert property (@(posedge clk) disable iff (reset_i)
      pc_q[1:0] == 2'b00);

endmodule

// ==== verilog/riscv_decode.sv ====
`timescale 1ns/1ps

module riscv_decode (
   input  logic                 clk,
   input  logic                 reset_i,
   input  riscv_pkg::word_t     instr_i,
   input  riscv_pkg::word_t     pc_i,
   input  logic                 flush_i,
   input  riscv_pkg::word_t     rs1_data_i,
   input  riscv_pkg::word_t     rs2_data_i,
   output riscv_pkg::reg_addr_t rs1_addr_o,
   output riscv_pkg::reg_addr_t rs2_addr_o,
   output logic                 stall_o,
   output riscv_pkg::reg_addr_t ex_rs1_o,
   output riscv_pkg::reg_addr_t ex_rs2_o,
   output riscv_pkg::reg_addr_t ex_rd_o,
   output riscv_pkg::word_t     ex_op1_o,
   output riscv_pkg::word_t     ex_op2_o,
   output riscv_pkg::word_t     ex_imm_o,
   output riscv_pkg::word_t     ex_pc_o,
   output riscv_pkg::alu_op_t   ex_alu_op_o,
   output logic                 ex_alu_src_o,
   output logic                 ex_mem_read_o,
   output logic                 ex_mem_write_o,
   output logic                 ex_reg_write_o,
   output logic                 ex_branch_o
);

   logic [6:0]         opcode;
   logic [2:0]         funct3;
   riscv_pkg::word_t   imm;
   riscv_pkg::alu_op_t alu_op;
   logic               alu_src;
   logic               mem_read;
   logic               mem_write;
   logic               reg_write;
   logic               branch;
   logic               uses_rs2;
   logic               bubble;

   assign opcode     = instr_i[6:0];
   assign funct3     = instr_i[14:12];
   assign rs1_addr_o = instr_i[19:15];
   assign rs2_addr_o = instr_i[24:20];

   always_comb begin
      alu_op    = riscv_pkg::ALU_ADD;
      alu_src   = 1'b0;
      mem_read  = 1'b0;
      mem_write = 1'b0;
      reg_write = 1'b0;
      branch    = 1'b0;
      uses_rs2  = 1'b0;
      imm       = {{20{instr_i[31]}}, instr_i[31:20]};        // I-type
      case (opcode)
         riscv_pkg::OPC_RTYPE: begin
            reg_write = 1'b1;
            uses_rs2  = 1'b1;
            case (funct3)
               3'b000:  alu_op = instr_i[30] ? riscv_pkg::ALU_SUB : riscv_pkg::ALU_ADD;
               3'b111:  alu_op = riscv_pkg::ALU_AND;
               3'b110:  alu_op = riscv_pkg::ALU_OR;
               3'b100:  alu_op = riscv_pkg::ALU_XOR;
               3'b010:  alu_op = riscv_pkg::ALU_SLT;
               default: reg_write = 1'b0;                    // Not in the subset
            endcase
         end
         riscv_pkg::OPC_ITYPE: begin
            alu_src   = 1'b1;
            reg_write = 1'b1;
         end
         riscv_pkg::OPC_LOAD: begin
            alu_src   = 1'b1;
            mem_read  = 1'b1;
            reg_write = 1'b1;
         end
         riscv_pkg::OPC_STORE: begin
            alu_src   = 1'b1;
            mem_write = 1'b1;
            uses_rs2  = 1'b1;
            imm       = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
         end
         riscv_pkg::OPC_BRANCH: begin
            branch   = 1'b1;
            uses_rs2 = 1'b1;
            alu_op   = riscv_pkg::ALU_SUB;
            imm      = {{19{instr_i[31]}}, instr_i[31], instr_i[7],
                        instr_i[30:25], instr_i[11:8], 1'b0};
         end
         default: ;                                           // Unknown, no effect
      endcase
   end

   // Load in execute feeding this instruction directly
   assign stall_o = ex_mem_read_o && (ex_rd_o != '0) &&
                    ((ex_rd_o == rs1_addr_o) || (uses_rs2 && ex_rd_o == rs2_addr_o));
   assign bubble  = stall_o || flush_i;

   // Decode/execute register, control part
   always_ff @(posedge clk) begin
      if (reset_i || bubble) begin
         ex_mem_read_o  <= 1'b0;
         ex_mem_write_o <= 1'b0;
         ex_reg_write_o <= 1'b0;
         ex_branch_o    <= 1'b0;
      end else begin
         ex_mem_read_o  <= mem_read;
         ex_mem_write_o <= mem_write;
         ex_reg_write_o <= reg_write;
         ex_branch_o    <= branch;
      end
   end

   // Decode/execute register, payload part
   always_ff @(posedge clk) begin
      ex_rs1_o     <= rs1_addr_o;
      ex_rs2_o     <= rs2_addr_o;
      ex_rd_o      <= instr_i[11:7];
      ex_op1_o     <= rs1_data_i;
      ex_op2_o     <= rs2_data_i;
      ex_imm_o     <= imm;
      ex_pc_o      <= pc_i;
      ex_alu_op_o  <= alu_op;
      ex_alu_src_o <= alu_src;
   end

   a_mem_excl: assert property (@(posedge clk) disable iff (reset_i)
      !(ex_mem_read_o && ex_mem_write_o));

endmodule

// ==== verilog/riscv_regfile.sv ====
`timescale 1ns/1ps

module riscv_regfile (
   input  logic                 clk,
   input  logic                 reset_i,
   input  riscv_pkg::reg_addr_t rs1_addr_i,
   input  riscv_pkg::reg_addr_t rs2_addr_i,
   input  riscv_pkg::reg_addr_t rd_addr_i,
   input  riscv_pkg::word_t     rd_data_i,
   input  logic                 rd_we_i,
   output riscv_pkg::word_t     rs1_data_o,
   output riscv_pkg::word_t     rs2_data_o
);

   riscv_pkg::word_t regs [32];

   always_ff @(posedge clk) begin
      if (reset_i) begin
         for (int i = 0; i < 32; i++) begin
            regs[i] <= '0;
         end
      end else if (rd_we_i && rd_addr_i != '0) begin
         regs[rd_addr_i] <= rd_data_i;                    // x0 stays zero
      end
   end

   // Reads see a write from the same cycle
   assign rs1_data_o = (rs1_addr_i == '0) ? '0 :
                       (rd_we_i && rd_addr_i == rs1_addr_i) ? rd_data_i : regs[rs1_addr_i];
   assign rs2_data_o = (rs2_addr_i == '0) ? '0 :
                       (rd_we_i && rd_addr_i == rs2_addr_i) ? rd_data_i : regs[rs2_addr_i];

endmodule

// ==== verilog/riscv_execute.sv ====
`timescale 1ns/1ps

module riscv_execute (
   input  logic                 clk,
   input  logic                 reset_i,
   input  riscv_pkg::reg_addr_t ex_rs1_i,
   input  riscv_pkg::reg_addr_t ex_rs2_i,
   input  riscv_pkg::reg_addr_t ex_rd_i,
   input  riscv_pkg::word_t     ex_op1_i,
   input  riscv_pkg::word_t     ex_op2_i,
   input  riscv_pkg::word_t     ex_imm_i,
   input  riscv_pkg::word_t     ex_pc_i,
   input  riscv_pkg::alu_op_t   ex_alu_op_i,
   input  logic                 ex_alu_src_i,
   input  logic                 ex_mem_read_i,
   input  logic                 ex_mem_write_i,
   input  logic                 ex_reg_write_i,
   input  logic                 ex_branch_i,
   input  riscv_pkg::reg_addr_t wb_rd_i,
   input  logic                 wb_reg_write_i,
   input  riscv_pkg::word_t     wb_data_i,
   output logic                 branch_taken_o,
   output riscv_pkg::word_t     branch_target_o,
   output riscv_pkg::word_t     mem_alu_result_o,
   output riscv_pkg::word_t     mem_store_data_o,
   output riscv_pkg::reg_addr_t mem_rd_o,
   output logic                 mem_read_o,
   output logic                 mem_write_o,
   output logic                 mem_reg_write_o
);

   riscv_pkg::word_t opa;
   riscv_pkg::word_t rs2_val;
   riscv_pkg::word_t opb;
   riscv_pkg::word_t alu_res;

   // Newest producer wins, x0 is never forwarded
   function automatic riscv_pkg::word_t fwd_sel(input riscv_pkg::reg_addr_t rs,
                                                input riscv_pkg::word_t rf_val);
      if (rs != '0 && mem_reg_write_o && mem_rd_o == rs) begin
         return mem_alu_result_o;
      end
      if (rs != '0 && wb_reg_write_i && wb_rd_i == rs) begin
         return wb_data_i;
      end
      return rf_val;
   endfunction

   assign opa     = fwd_sel(ex_rs1_i, ex_op1_i);
   assign rs2_val = fwd_sel(ex_rs2_i, ex_op2_i);
   assign opb     = ex_alu_src_i ? ex_imm_i : rs2_val;

   always_comb begin
      case (ex_alu_op_i)
         riscv_pkg::ALU_SUB: alu_res = opa - opb;
         riscv_pkg::ALU_AND: alu_res = opa & opb;
         riscv_pkg::ALU_OR:  alu_res = opa | opb;
         riscv_pkg::ALU_XOR: alu_res = opa ^ opb;
         riscv_pkg::ALU_SLT: alu_res = {31'd0, $signed(opa) < $signed(opb)};
         default:            alu_res = opa + opb;
      endcase
   end

   // BEQ resolves here and flushes fetch and decode
   assign branch_taken_o  = ex_branch_i && (opa == rs2_val);
   assign branch_target_o = ex_pc_i + ex_imm_i;

   // Execute/memory register, control part
   always_ff @(posedge clk) begin
      if (reset_i) begin
         mem_read_o      <= 1'b0;
         mem_write_o     <= 1'b0;
         mem_reg_write_o <= 1'b0;
      end else begin
         mem_read_o      <= ex_mem_read_i;
         mem_write_o     <= ex_mem_write_i;
         mem_reg_write_o <= ex_reg_write_i;
      end
   end

   always_ff @(posedge clk) begin
      mem_alu_result_o <= alu_res;
      mem_store_data_o <= rs2_val;                        // Forwarded store data
      mem_rd_o         <= ex_rd_i;
   end

   // The slot behind a taken branch must arrive as a bubble from decode
   a_flush_bubble: assert property (@(posedge clk) disable iff (reset_i)
      branch_taken_o |=> !(ex_reg_write_i || ex_mem_write_i || ex_mem_read_i || ex_branch_i));

endmodule

// ==== verilog/riscv_memwb.sv ====
`timescale 1ns/1ps

module riscv_memwb (
   input  logic                 clk,
   input  logic                 reset_i,
   input  riscv_pkg::word_t     alu_result_i,
   input  riscv_pkg::word_t     store_data_i,
   input  riscv_pkg::reg_addr_t rd_i,
   input  logic                 mem_read_i,
   input  logic                 mem_write_i,
   input  logic                 reg_write_i,
   input  riscv_pkg::word_t     data_i,
   output riscv_pkg::word_t     data_addr_o,
   output logic                 data_ce_o,
   output logic                 data_we_o,
   output riscv_pkg::word_t     data_o,
   output riscv_pkg::reg_addr_t wb_rd_o,
   output logic                 wb_reg_write_o,
   output riscv_pkg::word_t     wb_data_o
);

   // Data port, straight from the execute/memory register
   assign data_addr_o = alu_result_i;                    // LW/SW effective address
   assign data_ce_o   = mem_read_i || mem_write_i;
   assign data_we_o   = mem_write_i;
   assign data_o      = store_data_i;

   always_ff @(posedge clk) begin
      if (reset_i) begin
         wb_reg_write_o <= 1'b0;
      end else begin
         wb_reg_write_o <= reg_write_i;
      end
   end

   // Writeback select, load data or ALU result
   always_ff @(posedge clk) begin
      wb_rd_o   <= rd_i;
      wb_data_o <= mem_read_i ? data_i : alu_result_i;
   end

endmodule

// ==== verilog/riscv_core.sv ====
`timescale 1ns/1ps

module riscv_core #(
   parameter riscv_pkg::word_t RESET_PC = '0
) (
   input  logic             clk,
   input  logic             reset_i,
   input  riscv_pkg::word_t inst_i,
   input  riscv_pkg::word_t data_i,
   output riscv_pkg::word_t inst_addr_o,
   output logic             inst_ce_o,
   output riscv_pkg::word_t data_addr_o,
   output logic             data_ce_o,
   output logic             data_we_o,
   output riscv_pkg::word_t data_o
);

   // Fetch to decode
   riscv_pkg::word_t     if_id_instr;
   riscv_pkg::word_t     if_id_pc;
   logic                 stall;
   // Execute to fetch and decode
   logic                 branch_taken;
   riscv_pkg::word_t     branch_target;
   // Register file read ports
   riscv_pkg::reg_addr_t rs1_addr;
   riscv_pkg::reg_addr_t rs2_addr;
   riscv_pkg::word_t     rs1_data;
   riscv_pkg::word_t     rs2_data;
   // Decode/execute register
   riscv_pkg::reg_addr_t ex_rs1;
   riscv_pkg::reg_addr_t ex_rs2;
   riscv_pkg::reg_addr_t ex_rd;
   riscv_pkg::word_t     ex_op1;
   riscv_pkg::word_t     ex_op2;
   riscv_pkg::word_t     ex_imm;
   riscv_pkg::word_t     ex_pc;
   riscv_pkg::alu_op_t   ex_alu_op;
   logic                 ex_alu_src;
   logic                 ex_mem_read;
   logic                 ex_mem_write;
   logic                 ex_reg_write;
   logic                 ex_branch;
   // Execute/memory register
   riscv_pkg::word_t     mem_alu_result;
   riscv_pkg::word_t     mem_store_data;
   riscv_pkg::reg_addr_t mem_rd;
   logic                 mem_read;
   logic                 mem_write;
   logic                 mem_reg_write;
   // Writeback
   riscv_pkg::reg_addr_t wb_rd;
   logic                 wb_reg_write;
   riscv_pkg::word_t     wb_data;

   riscv_fetch #(.RESET_PC(RESET_PC)) u_fetch (
      .clk(clk), .reset_i(reset_i), .stall_i(stall),
      .branch_taken_i(branch_taken), .branch_target_i(branch_target),
      .inst_i(inst_i), .inst_addr_o(inst_addr_o), .inst_ce_o(inst_ce_o),
      .id_instr_o(if_id_instr), .id_pc_o(if_id_pc));

   riscv_decode u_decode (
      .clk(clk), .reset_i(reset_i), .instr_i(if_id_instr), .pc_i(if_id_pc),
      .flush_i(branch_taken), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
      .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .stall_o(stall),
      .ex_rs1_o(ex_rs1), .ex_rs2_o(ex_rs2), .ex_rd_o(ex_rd),
      .ex_op1_o(ex_op1), .ex_op2_o(ex_op2), .ex_imm_o(ex_imm), .ex_pc_o(ex_pc),
      .ex_alu_op_o(ex_alu_op), .ex_alu_src_o(ex_alu_src),
      .ex_mem_read_o(ex_mem_read), .ex_mem_write_o(ex_mem_write),
      .ex_reg_write_o(ex_reg_write), .ex_branch_o(ex_branch));

   riscv_regfile u_regfile (
      .clk(clk), .reset_i(reset_i), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr),
      .rd_addr_i(wb_rd), .rd_data_i(wb_data), .rd_we_i(wb_reg_write),
      .rs1_data_o(rs1_data), .rs2_data_o(rs2_data));

   riscv_execute u_execute (
      .clk(clk), .reset_i(reset_i),
      .ex_rs1_i(ex_rs1), .ex_rs2_i(ex_rs2), .ex_rd_i(ex_rd),
      .ex_op1_i(ex_op1), .ex_op2_i(ex_op2), .ex_imm_i(ex_imm), .ex_pc_i(ex_pc),
      .ex_alu_op_i(ex_alu_op), .ex_alu_src_i(ex_alu_src),
      .ex_mem_read_i(ex_mem_read), .ex_mem_write_i(ex_mem_write),
      .ex_reg_write_i(ex_reg_write), .ex_branch_i(ex_branch),
      .wb_rd_i(wb_rd), .wb_reg_write_i(wb_reg_write), .wb_data_i(wb_data),
      .branch_taken_o(branch_taken), .branch_target_o(branch_target),
      .mem_alu_result_o(mem_alu_result), .mem_store_data_o(mem_store_data),
      .mem_rd_o(mem_rd), .mem_read_o(mem_read), .mem_write_o(mem_write),
      .mem_reg_write_o(mem_reg_write));

   riscv_memwb u_memwb (
      .clk(clk), .reset_i(reset_i), .alu_result_i(mem_alu_result),
      .store_data_i(mem_store_data), .rd_i(mem_rd), .mem_read_i(mem_read),
      .mem_write_i(mem_write), .reg_write_i(mem_reg_write), .data_i(data_i),
      .data_addr_o(data_addr_o), .data_ce_o(data_ce_o), .data_we_o(data_we_o),
      .data_o(data_o), .wb_rd_o(wb_rd), .wb_reg_write_o(wb_reg_write),
      .wb_data_o(wb_data));

endmodule

// ==== tb/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
   parameter time PERIOD       = 100ns,
   parameter int  RESET_CYCLES = 4
) (
   output logic clk_o,
   output logic rst_o
);

   initial begin
      clk_o = 1'b0;
      forever #(PERIOD / 2) clk_o = ~clk_o;
   end

   // Power-on reset for the first few edges
   initial begin
      rst_o = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk_o);
      rst_o <= 1'b0;
   end

endmodule

// ==== tb/tb_riscv_core.sv ====
`timescale 1ns/1ps

module tb_riscv_core;

   localparam logic [31:0] RESET_PC    = 32'h0000_0100;
   localparam logic [31:0] NOP         = 32'h0000_0013;
   localparam int          TOTAL_INSTR = 35;               // Sum over all test programs
   localparam int          TIMEOUT     = 20 * TOTAL_INSTR;

   logic        clk;
   logic        por_rst;
   logic        test_rst;
   logic        reset_i;
   logic [31:0] inst_i;
   logic [31:0] data_i;
   logic [31:0] inst_addr_o;
   logic        inst_ce_o;
   logic [31:0] data_addr_o;
   logic        data_ce_o;
   logic        data_we_o;
   logic [31:0] data_o;

   logic [31:0] imem [256];
   logic [31:0] dmem [256];
   logic [7:0]  inst_idx;
   logic [31:0] prog [$];
   logic [31:0] exp_addr [$];
   logic [31:0] exp_data [$];
   logic [31:0] wr_addr [$];
   logic [31:0] wr_data [$];
   integer      seed = 32'ha77a_83a3;
   int          cycles = 0;

   tb_clock #(.PERIOD(100ns), .RESET_CYCLES(4)) u_clock (.clk_o(clk), .rst_o(por_rst));

   riscv_core #(.RESET_PC(RESET_PC)) dut0 (
      .clk(clk), .reset_i(reset_i), .inst_i(inst_i), .data_i(data_i),
      .inst_addr_o(inst_addr_o), .inst_ce_o(inst_ce_o), .data_addr_o(data_addr_o),
      .data_ce_o(data_ce_o), .data_we_o(data_we_o), .data_o(data_o));

   initial test_rst = 1'b0;
   assign reset_i  = por_rst | test_rst;
   assign inst_idx = 8'((inst_addr_o - RESET_PC) >> 2);   // Word index into the program
   assign inst_i   = imem[inst_idx];                       // Combinational fetch
   assign data_i   = dmem[data_addr_o[9:2]];

   // Data memory write port that also logs every write
   always @(posedge clk) begin
      if (!reset_i && data_ce_o && data_we_o) begin
         dmem[data_addr_o[9:2]] <= data_o;
         wr_addr.push_back(data_addr_o);
         wr_data.push_back(data_o);
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT) begin
         $display("Timeout after %0d cycles, expected stores never completed", cycles);
         $display("TEST FAILED");
         $fatal(1);
      end
   end

   function automatic logic [31:0] sext12(input logic [11:0] v);
      return {{20{v[11]}}, v};
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, 7'b0110011};
   endfunction

   function automatic logic [31:0] enc_addi(input logic [4:0] rd, input logic [4:0] rs1,
                                            input logic [11:0] imm);
      return {imm, rs1, 3'b000, rd, 7'b0010011};
   endfunction

   function automatic logic [31:0] enc_lw(input logic [4:0] rd, input logic [11:0] off);
      return {off, 5'd0, 3'b010, rd, 7'b0000011};           // Base is always x0
   endfunction

   function automatic logic [31:0] enc_sw(input logic [4:0] rs2, input logic [11:0] off);
      return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
   endfunction

   function automatic logic [31:0] enc_beq(input logic [4:0] rs1, input logic [4:0] rs2,
                                           input logic [12:0] off);
      return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
   endfunction

   task automatic check_word(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
      assert (exp === act) else begin
         $display("MISMATCH %s expected %08h actual %08h", name, exp, act);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   task automatic expect_store(input logic [31:0] addr, input logic [31:0] data);
      exp_addr.push_back(addr);
      exp_data.push_back(data);
   endtask

   // Loads the program under reset and compares the logged stores in order
   task automatic run_program();
      @(posedge clk);
      test_rst <= 1'b1;
      repeat (4) @(posedge clk);
      for (int i = 0; i < 256; i++) begin
         imem[i] = (i < prog.size()) ? prog[i] : NOP;
      end
      wr_addr.delete();
      wr_data.delete();
      test_rst <= 1'b0;
      while (wr_addr.size() < exp_addr.size()) @(posedge clk);
      repeat (12) @(posedge clk);                           // Catch any stray store
      assert (wr_addr.size() == exp_addr.size()) else begin
         $display("Store count wrong, %0d seen but %0d expected",
                  wr_addr.size(), exp_addr.size());
         $display("TEST FAILED");
         $fatal(1);
      end
      for (int i = 0; i < exp_addr.size(); i++) begin
         check_word("data_addr_o", exp_addr[i], wr_addr[i]);
         check_word("data_o", exp_data[i], wr_data[i]);
      end
      prog.delete();
      exp_addr.delete();
      exp_data.delete();
   endtask

   task automatic test_after_reset();
      @(posedge clk);
      test_rst <= 1'b1;
      repeat (3) @(posedge clk);
      check_word("data_ce_o", 32'(0), 32'(data_ce_o));
      check_word("data_we_o", 32'(0), 32'(data_we_o));
      check_word("inst_addr_o", RESET_PC, inst_addr_o);
      test_rst <= 1'b0;
      @(posedge clk);
      check_word("inst_addr_o", RESET_PC, inst_addr_o);
      @(posedge clk);
      check_word("inst_ce_o", 32'(1), 32'(inst_ce_o));      // Fetch starts at RESET_PC
      check_word("inst_addr_o", RESET_PC, inst_addr_o);
      check_word("data_ce_o", 32'(0), 32'(data_ce_o));
      check_word("data_we_o", 32'(0), 32'(data_we_o));
   endtask

   task automatic test_alu_chain();
      logic [31:0] a;
      logic [31:0] b;
      logic [11:0] imm;
      logic [31:0] r [3:9];
      a = $random(seed);
      b = $random(seed);
      imm = 12'($random(seed));
      for (int i = 0; i < 256; i++) begin
         dmem[i] = 32'hd000_0000 | i;
      end
      dmem[0] = a;
      dmem[1] = b;
      r[3] = a + sext12(imm);
      r[4] = r[3] + b;
      r[5] = r[4] - a;
      r[6] = r[5] & b;
      r[7] = r[6] | r[3];
      r[8] = r[7] ^ a;
      r[9] = ($signed(r[8]) < $signed(b)) ? 32'd1 : 32'd0;
      prog = '{enc_lw(1, 0), enc_lw(2, 4), enc_addi(3, 1, imm),
               enc_r(7'h00, 2, 3, 3'b000, 4), enc_r(7'h20, 1, 4, 3'b000, 5),
               enc_r(7'h00, 2, 5, 3'b111, 6), enc_r(7'h00, 3, 6, 3'b110, 7),
               enc_r(7'h00, 1, 7, 3'b100, 8), enc_r(7'h00, 2, 8, 3'b010, 9),
               enc_sw(9, 12'h40), enc_sw(3, 12'h44), enc_sw(4, 12'h48),
               enc_sw(5, 12'h4c), enc_sw(6, 12'h50), enc_sw(7, 12'h54),
               enc_sw(8, 12'h58)};
      expect_store(32'h40, r[9]);
      for (int i = 3; i <= 8; i++) begin
         expect_store(32'h44 + 4 * (i - 3), r[i]);
      end
      run_program();
   endtask

   task automatic test_load_use();
      logic [31:0] c;
      logic [11:0] d;
      c = $random(seed);
      d = 12'($random(seed));
      dmem[0] = c;
      prog = '{enc_addi(2, 0, d), enc_lw(1, 0), enc_r(7'h00, 2, 1, 3'b000, 3),
               enc_sw(3, 12'h80)};
      expect_store(32'h80, c + sext12(d));
      run_program();
   endtask

   task automatic test_branch();
      // Taken BEQ skips two stores and the second BEQ falls through
      prog = '{enc_addi(1, 0, 5), enc_addi(2, 0, 5), enc_addi(3, 0, 7),
               enc_beq(1, 2, 13'd12), enc_sw(3, 12'h90), enc_sw(3, 12'h94),
               enc_sw(1, 12'h98), enc_beq(1, 3, 13'd8), enc_sw(2, 12'h9c),
               enc_sw(3, 12'ha0)};
      expect_store(32'h98, 32'd5);
      expect_store(32'h9c, 32'd5);
      expect_store(32'ha0, 32'd7);
      run_program();
   endtask

   task automatic test_x0();
      prog = '{enc_addi(1, 0, 55), enc_r(7'h00, 1, 1, 3'b000, 0), enc_sw(0, 12'hb0),
               enc_addi(0, 0, 77), enc_sw(0, 12'hb4)};
      expect_store(32'hb0, 32'd0);
      expect_store(32'hb4, 32'd0);
      run_program();
   endtask

   initial begin
      for (int i = 0; i < 256; i++) begin
         imem[i] = NOP;
         dmem[i] = 32'hd000_0000 | i;                       // Address-tagged fill
      end
      @(negedge por_rst);
      test_after_reset();
      test_alu_chain();
      test_load_use();
      test_branch();
      test_x0();
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== riscv_pipe.f ====
verilog/riscv_pkg.sv
verilog/riscv_fetch.sv
verilog/riscv_decode.sv
verilog/riscv_regfile.sv
verilog/riscv_execute.sv
verilog/riscv_memwb.sv
verilog/riscv_core.sv
tb/tb_clock.sv
tb/tb_riscv_core.sv

// ==== Makefile ====
# Verilator build and run for the RV32I pipeline

VERILATOR ?= verilator
TOP       ?= tb_riscv_core
FILELIST  ?= riscv_pipe.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST OK" $(LOG); then echo "Simulation ended without verdict"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
